//--- flist.f
+incdir+tb
source/uno_pkg.sv
source/card_source.sv
source/card_rules.sv
source/hand_counter.sv
source/turn_sequencer.sv
source/uno_table.sv
tb/uno_table_tb.sv

//--- source/card_rules.sv
`timescale 1ns/1ps

module card_rules import uno_pkg::*; (
    input  seat_t        i_seat,
    input  logic         i_reversed,
    input  card_t        i_card,
    output rule_result_t o_result
);

    logic  dir_rev;
    seat_t hop;
    logic [DRAW_W-1:0] penalty;

    always_comb begin
        dir_rev = i_reversed;
        hop     = 2'd1;
        penalty = '0;
        case (i_card.rank)
            RANK_SKIP: begin
                hop = 2'd2;                               // jump over one seat
            end
            RANK_REVERSE: begin
                dir_rev = ~i_reversed;                    // step in the new direction
            end
            RANK_DRAW_TWO: begin
                penalty = PENALTY_TWO;
            end
            RANK_WILD_DRAW_FOUR: begin
                penalty = PENALTY_FOUR;
            end
            default: begin
                hop = 2'd1;                               // number cards and wild
            end
        endcase
    end

    // forward means seat 0 -> 1 -> 2 -> 3
    assign o_result.next_seat = dir_rev ? (i_seat - hop) : (i_seat + hop);
    assign o_result.reversed  = dir_rev;
    assign o_result.penalty   = penalty;

endmodule

//--- source/card_source.sv
`timescale 1ns/1ps

module card_source import uno_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  draw_req_t   i_req,
    output dealt_card_t o_card,
    output logic        o_idle
);

    logic [LFSR_W-1:0] lfsr_r;
    logic              feedback;
    logic [DRAW_W-1:0] left_r;
    logic              valid_r;
    seat_t             target_r;
    card_t             card_r;
    card_t             rand_card;

    assign feedback = lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10];

    // rank 15 folds back into 0 to 7
    assign rand_card.color = lfsr_r[9:8];
    assign rand_card.rank  = (lfsr_r[3:0] == 4'hf) ? {1'b0, lfsr_r[6:4]} : lfsr_r[3:0];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            lfsr_r  <= LFSR_SEED;
            left_r  <= '0;
            valid_r <= 1'b0;
        end
        else begin
            lfsr_r <= {lfsr_r[LFSR_W-2:0], feedback};    // free running
            if (i_req.req) begin
                left_r  <= i_req.count;
                valid_r <= 1'b0;
            end
            else if (left_r != '0) begin
                left_r  <= left_r - 1'b1;
                valid_r <= 1'b1;
            end
            else begin
                valid_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req.req) begin
            target_r <= i_req.seat;
        end
        if (left_r != '0) begin
            card_r <= rand_card;
        end
    end

    assign o_card = '{valid: valid_r, seat: target_r, card: card_r};
    assign o_idle = (left_r == '0) && !valid_r;         // last card already on o_card

    // the sequencer must wait for idle before the next request
    a_no_req_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_req.req |-> o_idle);

endmodule

//--- source/hand_counter.sv
`timescale 1ns/1ps

module hand_counter import uno_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_clear,
    input  dealt_card_t       i_dealt,
    input  play_evt_t         i_play,
    output logic [HAND_W-1:0] o_hand_num [NUM_SEATS]
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_hand_num <= '{default: '0};
        end
        else if (i_clear) begin
            o_hand_num <= '{default: '0};                 // new game
        end
        else begin
            // a deal and a play on one seat cancel out
            for (int s = 0; s < NUM_SEATS; s++) begin
                o_hand_num[s] <= o_hand_num[s]
                               + HAND_W'(i_dealt.valid && (i_dealt.seat == seat_t'(s)))
                               - HAND_W'(i_play.valid && (i_play.seat == seat_t'(s)));
            end
        end
    end

    // the sequencer only accepts plays from a seat holding cards
    a_play_nonempty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_play.valid |-> (o_hand_num[i_play.seat] != '0));

endmodule

//--- source/turn_sequencer.sv
`timescale 1ns/1ps

module turn_sequencer import uno_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  seat_action_t      i_action,
    input  logic              i_src_idle,
    input  dealt_card_t       i_dealt,
    input  logic [HAND_W-1:0] i_hand_num [NUM_SEATS],
    output draw_req_t         o_req,
    output play_evt_t         o_play,
    output logic              o_clear,
    output seat_t             o_turn,
    output logic              o_turn_valid,
    output logic              o_reversed,
    output card_t             o_last_card,
    output logic              o_end
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DEAL,
        S_TURN,
        S_DRAW_WAIT,
        S_PENALTY,
        S_END
    } state_t;

    state_t                state_w, state_r;
    seat_t                 seat_w, seat_r;
    logic                  reversed_w, reversed_r;
    card_t                 last_card_w, last_card_r;
    logic [DEAL_CNT_W-1:0] deal_cnt_w, deal_cnt_r;
    logic [DRAW_W-1:0]     pen_r;
    logic                  accept_play;
    logic                  accept_draw;
    card_t                 rule_card;
    rule_result_t          rule;
    draw_req_t             req;

    assign accept_play = (state_r == S_TURN) && i_action.play;
    assign accept_draw = (state_r == S_TURN) && i_action.draw && !i_action.play;

    // a draw steps like a number card
    assign rule_card = i_action.play ? i_action.card : card_t'('0);

    card_rules card_rules_inst (
        .i_seat     (seat_r),
        .i_reversed (reversed_r),
        .i_card     (rule_card),
        .o_result   (rule)
    );

    always_comb begin
        state_w     = state_r;
        seat_w      = seat_r;
        reversed_w  = reversed_r;
        last_card_w = last_card_r;
        deal_cnt_w  = deal_cnt_r;
        req         = '0;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w     = S_DEAL;
                    seat_w      = '0;
                    reversed_w  = 1'b0;
                    last_card_w = '0;
                    deal_cnt_w  = '0;
                end
            end
            S_DEAL: begin
                if (i_dealt.valid) begin
                    deal_cnt_w = deal_cnt_r + 1'b1;
                end
                if (i_src_idle) begin
                    if (deal_cnt_r == DEAL_CNT_W'(DEAL_TOTAL)) begin
                        state_w = S_TURN;                 // seat_r has wrapped back to 0
                    end
                    else begin
                        req    = '{req: 1'b1, count: DRAW_W'(DEAL_SIZE), seat: seat_r};
                        seat_w = seat_r + 1'b1;
                    end
                end
            end
            S_TURN: begin
                if (accept_play) begin
                    last_card_w = i_action.card;
                    if (i_hand_num[seat_r] == HAND_W'(1)) begin
                        state_w = S_END;
                    end
                    else begin
                        seat_w     = rule.next_seat;
                        reversed_w = rule.reversed;
                        if (rule.penalty != '0) begin
                            state_w = S_PENALTY;          // seat_w is the victim
                        end
                    end
                end
                else if (accept_draw) begin
                    req     = '{req: 1'b1, count: DRAW_W'(1), seat: seat_r};
                    seat_w  = rule.next_seat;
                    state_w = S_DRAW_WAIT;
                end
            end
            S_PENALTY: begin
                if (i_src_idle) begin
                    req     = '{req: 1'b1, count: pen_r, seat: seat_r};
                    state_w = S_DRAW_WAIT;
                end
            end
            S_DRAW_WAIT: begin
                if (i_src_idle) begin
                    state_w = S_TURN;
                end
            end
            S_END: begin
                if (!i_start) begin
                    state_w = S_IDLE;
                end
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r     <= S_IDLE;
            seat_r      <= '0;
            reversed_r  <= 1'b0;
            last_card_r <= '0;
            deal_cnt_r  <= '0;
        end
        else begin
            state_r     <= state_w;
            seat_r      <= seat_w;
            reversed_r  <= reversed_w;
            last_card_r <= last_card_w;
            deal_cnt_r  <= deal_cnt_w;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept_play) begin
            pen_r <= rule.penalty;
        end
    end

    assign o_req        = req;
    assign o_play       = '{valid: accept_play, seat: seat_r};
    assign o_clear      = (state_r == S_IDLE) && i_start;
    assign o_turn       = seat_r;
    assign o_turn_valid = (state_r == S_TURN);
    assign o_reversed   = reversed_r;
    assign o_last_card  = last_card_r;
    assign o_end        = (state_r == S_END);

    // no cards still in flight while a seat may act
    a_turn_src_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_turn_valid |-> i_src_idle);

endmodule

//--- source/uno_pkg.sv
package uno_pkg;

    localparam int NUM_SEATS  = 4;                        // seat 0 human, 1 to 3 computers
    localparam int DEAL_SIZE  = 7;
    localparam int DEAL_TOTAL = NUM_SEATS * DEAL_SIZE;
    localparam int DEAL_CNT_W = $clog2(DEAL_TOTAL + 1);
    localparam int HAND_W     = 7;
    localparam int DRAW_W     = 3;
    localparam int LFSR_W     = 16;

    // ranks 0 to 9 are number cards
    localparam logic [3:0] RANK_SKIP           = 4'd10;
    localparam logic [3:0] RANK_REVERSE        = 4'd11;
    localparam logic [3:0] RANK_DRAW_TWO       = 4'd12;
    localparam logic [3:0] RANK_WILD           = 4'd13;
    localparam logic [3:0] RANK_WILD_DRAW_FOUR = 4'd14;

    localparam logic [DRAW_W-1:0] PENALTY_TWO  = 3'd2;
    localparam logic [DRAW_W-1:0] PENALTY_FOUR = 3'd4;

    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hb5e3;

    typedef logic [1:0] seat_t;

    typedef struct packed {
        logic [1:0] color;
        logic [3:0] rank;
    } card_t;

    typedef struct packed {
        logic  play;
        logic  draw;
        card_t card;
    } seat_action_t;

    typedef struct packed {
        logic              req;
        logic [DRAW_W-1:0] count;
        seat_t             seat;                          // who receives the cards
    } draw_req_t;

    typedef struct packed {
        logic  valid;
        seat_t seat;
        card_t card;
    } dealt_card_t;

    typedef struct packed {
        logic  valid;
        seat_t seat;
    } play_evt_t;

    typedef struct packed {
        seat_t             next_seat;
        logic              reversed;
        logic [DRAW_W-1:0] penalty;                       // 0 when no one draws
    } rule_result_t;

endpackage

//--- source/uno_table.sv
`timescale 1ns/1ps

module uno_table import uno_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  seat_action_t      i_action,
    output seat_t             o_turn,
    output logic              o_turn_valid,
    output logic              o_reversed,
    output card_t             o_last_card,
    output logic [HAND_W-1:0] o_hand_num [NUM_SEATS],
    output logic              o_end
);

    draw_req_t   draw_req;
    dealt_card_t dealt_card;
    play_evt_t   play_evt;
    logic        src_idle;
    logic        clear;

    turn_sequencer turn_sequencer_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_action     (i_action),
        .i_src_idle   (src_idle),
        .i_dealt      (dealt_card),
        .i_hand_num   (o_hand_num),
        .o_req        (draw_req),
        .o_play       (play_evt),
        .o_clear      (clear),
        .o_turn       (o_turn),
        .o_turn_valid (o_turn_valid),
        .o_reversed   (o_reversed),
        .o_last_card  (o_last_card),
        .o_end        (o_end)
    );

    card_source card_source_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (draw_req),
        .o_card  (dealt_card),
        .o_idle  (src_idle)
    );

    hand_counter hand_counter_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clear    (clear),
        .i_dealt    (dealt_card),
        .i_play     (play_evt),
        .o_hand_num (o_hand_num)
    );

endmodule

//--- tb/uno_stimulus.svh
`ifndef UNO_STIMULUS_SVH
`define UNO_STIMULUS_SVH

// columns: draw (1 draws a card, 0 plays one), rank of the played card
// the color of each played card comes from $random in the testbench
typedef struct packed {
    logic       draw;
    logic [3:0] rank;
} stim_row_t;

localparam logic ACT_PLAY = 1'b0;
localparam logic ACT_DRAW = 1'b1;

localparam int NUM_ROWS = 32;

localparam stim_row_t STIM_ROWS [NUM_ROWS] = '{
    '{ACT_PLAY, 4'd3},
    '{ACT_PLAY, RANK_SKIP},
    '{ACT_PLAY, RANK_REVERSE},                  // direction now reversed
    '{ACT_PLAY, 4'd7},
    '{ACT_DRAW, 4'd0},
    '{ACT_PLAY, RANK_DRAW_TWO},
    '{ACT_PLAY, RANK_WILD},
    '{ACT_PLAY, RANK_WILD_DRAW_FOUR},
    '{ACT_PLAY, RANK_REVERSE},
    '{ACT_PLAY, 4'd0},
    '{ACT_PLAY, RANK_SKIP},
    '{ACT_DRAW, 4'd0},
    '{ACT_PLAY, 4'd9},
    '{ACT_PLAY, 4'd1},
    '{ACT_PLAY, 4'd2},
    '{ACT_PLAY, RANK_SKIP},
    '{ACT_PLAY, RANK_REVERSE},
    '{ACT_PLAY, 4'd4},
    '{ACT_PLAY, RANK_REVERSE},
    '{ACT_PLAY, 4'd5},
    '{ACT_PLAY, RANK_REVERSE},
    '{ACT_PLAY, 4'd6},                          // seat 2 empties its hand
    '{ACT_PLAY, 4'd8},
    '{ACT_DRAW, 4'd0},
    '{ACT_PLAY, RANK_DRAW_TWO},
    '{ACT_PLAY, RANK_WILD_DRAW_FOUR},
    '{ACT_PLAY, RANK_WILD},
    '{ACT_PLAY, RANK_REVERSE},
    '{ACT_PLAY, RANK_SKIP},
    '{ACT_DRAW, 4'd0},
    '{ACT_PLAY, RANK_DRAW_TWO},
    '{ACT_PLAY, 4'd3}
};

`endif

//--- tb/uno_table_tb.sv
`timescale 1ns/1ps

module uno_table_tb
    import uno_pkg::*;
();

    `include "uno_stimulus.svh"

    localparam int CYCLE_LIMIT = 16 + 200 + 20 * NUM_ROWS;

    logic              clk;
    logic              rst_n;
    logic              start;
    seat_action_t      action;
    seat_t             turn;
    logic              turn_valid;
    logic              reversed;
    card_t             last_card;
    logic [HAND_W-1:0] hand_num [NUM_SEATS];
    logic              game_end;

    integer seed;
    int     cycles      = 0;
    int     checks      = 0;
    int     errors      = 0;

    // reference model of the table
    int    m_seat;
    logic  m_rev;
    int    m_count [NUM_SEATS];
    card_t m_last;

    uno_table uno_table_inst (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .i_action     (action),
        .o_turn       (turn),
        .o_turn_valid (turn_valid),
        .o_reversed   (reversed),
        .o_last_card  (last_card),
        .o_hand_num   (hand_num),
        .o_end        (game_end)
    );

    always #10 clk = ~clk;                                // 20 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic int step_seat(input int from, input int hops, input logic rev);
        if (rev) begin
            return (from - hops + NUM_SEATS) % NUM_SEATS;
        end
        return (from + hops) % NUM_SEATS;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic compare_state();
        check_value("o_turn", turn, m_seat);
        check_value("o_reversed", reversed, m_rev);
        check_value("o_last_card", last_card, m_last);
        for (int s = 0; s < NUM_SEATS; s++) begin
            check_value($sformatf("o_hand_num[%0d]", s), hand_num[s], m_count[s]);
        end
    endtask

    task automatic reset_model(input int hand_size);
        m_seat = 0;
        m_rev  = 1'b0;
        m_last = '0;
        for (int s = 0; s < NUM_SEATS; s++) begin
            m_count[s] = hand_size;
        end
    endtask

    task automatic advance_model(input stim_row_t row, input card_t card, output logic over);
        int actor;
        int neighbor;
        actor    = m_seat;
        neighbor = step_seat(actor, 1, m_rev);
        over     = 1'b0;
        if (row.draw) begin
            m_count[actor]++;
            m_seat = neighbor;
        end
        else begin
            m_count[actor]--;
            m_last = card;
            if (m_count[actor] == 0) begin
                over = 1'b1;                              // seat and direction freeze
            end
            else begin
                case (row.rank)
                    RANK_SKIP: begin
                        m_seat = step_seat(actor, 2, m_rev);
                    end
                    RANK_REVERSE: begin
                        m_rev  = !m_rev;
                        m_seat = step_seat(actor, 1, m_rev);
                    end
                    RANK_DRAW_TWO: begin
                        m_count[neighbor] += 2;           // victim keeps the turn
                        m_seat = neighbor;
                    end
                    RANK_WILD_DRAW_FOUR: begin
                        m_count[neighbor] += 4;
                        m_seat = neighbor;
                    end
                    default: begin
                        m_seat = neighbor;
                    end
                endcase
            end
        end
    endtask

    task automatic wait_for_turn();
        while (!turn_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic start_game();
        start = 1'b1;
        wait_for_turn();
        reset_model(DEAL_SIZE);
        check_value("o_end", game_end, 0);
        compare_state();
    endtask

    task automatic finish_game();
        check_value("o_end", game_end, 1);
        check_value("o_turn_valid", turn_valid, 0);
        compare_state();
        @(negedge clk);
        check_value("o_end", game_end, 1);                // held while start stays high
        start = 1'b0;
        @(negedge clk);
        check_value("o_end", game_end, 0);
        start_game();
    endtask

    task automatic apply_row(input stim_row_t row);
        card_t card;
        logic  over;
        logic  deals_cards;
        card.color  = 2'($random(seed));
        card.rank   = row.rank;
        deals_cards = row.draw || (row.rank == RANK_DRAW_TWO)
                    || (row.rank == RANK_WILD_DRAW_FOUR);
        action = '{play: !row.draw, draw: row.draw, card: card};
        advance_model(row, card, over);
        @(negedge clk);
        action = '0;
        if (over) begin
            finish_game();
        end
        else if (deals_cards) begin
            check_value("o_turn_valid", turn_valid, 0);
            wait_for_turn();
            compare_state();
        end
        else begin
            check_value("o_turn_valid", turn_valid, 1);
            compare_state();
        end
    endtask

    initial begin
        seed   = 32'h692c45a8;
        clk    = 1'b0;
        rst_n  = 1'b0;
        start  = 1'b0;
        action = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_value("o_turn_valid", turn_valid, 0);
        check_value("o_end", game_end, 0);
        reset_model(0);
        compare_state();

        start_game();
        for (int r = 0; r < NUM_ROWS; r++) begin
            wait_for_turn();
            apply_row(STIM_ROWS[r]);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
